/* design/rbk_pkg.sv */
/*
 * shared definitions for the tile rearrangement engine
 * - widths and vector types for addresses, data and tile counts
 * - operation mode enum
 * - buffer and tile size limits
 * - register index map
 */
`default_nettype none

package rbk_pkg;

  // ==============================
  // types
  // ==============================
  typedef logic [31:0] addr_t;      // word address, no byte lanes
  typedef logic [31:0] word_t;
  typedef logic [4:0]  rf_addr_t;   // tile buffer index
  typedef logic [3:0]  dim_w_t;     // 1..8 words
  typedef logic [2:0]  dim_h_t;     // 1..4 lines
  typedef logic [5:0]  tile_cnt_t;  // up to 32 words
  typedef logic [2:0]  reg_addr_t;

  typedef enum logic {
    RBK_COPY      = 1'b0,
    RBK_TRANSPOSE = 1'b1
  } rubik_mode_t;

  // ==============================
  // sizes
  // ==============================
  localparam int RF_DEPTH = 32;
  localparam int MAX_W    = 8;
  localparam int MAX_H    = 4;

  // ==============================
  // register map
  // ==============================
  localparam reg_addr_t REG_DAIN_ADDR    = 3'd0;
  localparam reg_addr_t REG_DAIN_STRIDE  = 3'd1;
  localparam reg_addr_t REG_DAOUT_ADDR   = 3'd2;
  localparam reg_addr_t REG_DAOUT_STRIDE = 3'd3;
  localparam reg_addr_t REG_SIZE         = 3'd4;  // w in 3:0, h in 6:4
  localparam reg_addr_t REG_MODE         = 3'd5;
  localparam reg_addr_t REG_OP_EN        = 3'd6;  // write starts an op

endpackage

`default_nettype wire

/* design/rbk_regfile.sv */
/*
 * configuration register block
 * - decodes host write strobes into the configuration registers
 * - clamps tile width and height to the legal range
 * - op_en pulse generation with a busy level that drops late starts
 */
`timescale 1ns/10ps
`default_nettype none

module rbk_regfile import rbk_pkg::*; (
  input  wire logic        nvdla_core_clk,
  input  wire logic        rst_n,
  input  wire logic        reg_wr_en,
  input  wire reg_addr_t   reg_addr,
  input  wire word_t       reg_wdata,
  input  wire logic        done,
  output logic             op_en,
  output addr_t            dain_addr,
  output addr_t            dain_stride,
  output addr_t            daout_addr,
  output addr_t            daout_stride,
  output dim_w_t           tile_w,
  output dim_h_t           tile_h,
  output rubik_mode_t      mode
);

  logic   busy;
  logic   op_wr;
  dim_w_t size_w;
  dim_h_t size_h;

  assign op_wr = reg_wr_en & (reg_addr == REG_OP_EN);

  // zero means one, anything past the max saturates
  always_comb begin
    size_w = dim_w_t'(reg_wdata[3:0]);
    size_h = dim_h_t'(reg_wdata[6:4]);
    if (size_w == '0) size_w = dim_w_t'(1);
    else if (size_w > dim_w_t'(MAX_W)) size_w = dim_w_t'(MAX_W);
    if (size_h == '0) size_h = dim_h_t'(1);
    else if (size_h > dim_h_t'(MAX_H)) size_h = dim_h_t'(MAX_H);
  end

  // ==============================
  // configuration registers
  // ==============================
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      dain_addr    <= '0;
      dain_stride  <= '0;
      daout_addr   <= '0;
      daout_stride <= '0;
      tile_w       <= dim_w_t'(1);
      tile_h       <= dim_h_t'(1);
      mode         <= RBK_COPY;
    end else if (reg_wr_en) begin
      case (reg_addr)
        REG_DAIN_ADDR:    dain_addr    <= reg_wdata;
        REG_DAIN_STRIDE:  dain_stride  <= reg_wdata;
        REG_DAOUT_ADDR:   daout_addr   <= reg_wdata;
        REG_DAOUT_STRIDE: daout_stride <= reg_wdata;
        REG_SIZE: begin
          tile_w <= size_w;
          tile_h <= size_h;
        end
        REG_MODE:         mode <= rubik_mode_t'(reg_wdata[0]);
        default: ;                                 // op_en handled below
      endcase
    end
  end

  // start pulse, also blocked in the cycle op_en is already up
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      op_en <= 1'b0;
      busy  <= 1'b0;
    end else begin
      op_en <= op_wr & ~busy & ~op_en;
      if (op_en) busy <= 1'b1;
      else if (done) busy <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* design/rbk_seq_gen.sv */
/*
 * read sequencer (producer)
 * - walks the input tile line by line and issues read requests
 * - counts in-order read responses and writes them into the tile buffer
 * - flags the last response so the buffer can mark the tile full
 */
`timescale 1ns/10ps
`default_nettype none

module rbk_seq_gen import rbk_pkg::*; (
  input  wire logic   nvdla_core_clk,
  input  wire logic   rst_n,
  input  wire logic   op_en,
  input  wire addr_t  dain_addr,
  input  wire addr_t  dain_stride,
  input  wire dim_w_t tile_w,
  input  wire dim_h_t tile_h,
  input  wire logic   rd_req_ready,
  input  wire logic   rd_rsp_valid,
  input  wire word_t  rd_rsp_data,
  input  wire logic   rf_wr_rdy,
  output logic        rd_req_valid,
  output addr_t       rd_req_addr,
  output logic        rf_wr_en,
  output rf_addr_t    rf_wr_addr,
  output word_t       rf_wr_data,
  output logic        rf_wr_last
);

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_ISSUE,
    SEQ_DRAIN
  } seq_state_t;

  seq_state_t state;
  dim_w_t     x_cnt;
  dim_h_t     y_cnt;
  addr_t      line_base;   // dain base plus y lines
  tile_cnt_t  rsp_cnt;
  tile_cnt_t  tile_total;
  logic       req_go;
  logic       x_last;
  logic       y_last;
  logic       rsp_last;

  assign tile_total = tile_cnt_t'(tile_w) * tile_cnt_t'(tile_h);
  assign req_go     = rd_req_valid & rd_req_ready;
  assign x_last     = (x_cnt == tile_w - dim_w_t'(1));
  assign y_last     = (y_cnt == tile_h - dim_h_t'(1));
  assign rsp_last   = rd_rsp_valid & (rsp_cnt == tile_total - tile_cnt_t'(1));

  // ==============================
  // request side FSM
  // ==============================
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= SEQ_IDLE;
      rd_req_valid <= 1'b0;
      x_cnt        <= '0;
      y_cnt        <= '0;
      rsp_cnt      <= '0;
    end else begin
      if (state == SEQ_IDLE) rsp_cnt <= '0;
      else if (rd_rsp_valid) rsp_cnt <= rsp_cnt + tile_cnt_t'(1);
      case (state)
        SEQ_IDLE: begin
          if (op_en && rf_wr_rdy) begin
            state        <= SEQ_ISSUE;
            rd_req_valid <= 1'b1;
            x_cnt        <= '0;
            y_cnt        <= '0;
          end
        end
        SEQ_ISSUE: begin
          if (req_go) begin
            if (x_last) begin
              x_cnt <= '0;
              if (y_last) begin
                rd_req_valid <= 1'b0;                 // all lines issued
                state        <= SEQ_DRAIN;
              end else begin
                y_cnt <= y_cnt + dim_h_t'(1);
              end
            end else begin
              x_cnt <= x_cnt + dim_w_t'(1);
            end
          end
        end
        SEQ_DRAIN: if (rsp_last) state <= SEQ_IDLE;   // wait for the last data
        default:   state <= SEQ_IDLE;
      endcase
    end
  end

  // address held stable until the request is taken
  always_ff @(posedge nvdla_core_clk) begin
    if (state == SEQ_IDLE) begin
      line_base   <= dain_addr;
      rd_req_addr <= dain_addr;
    end else if (req_go) begin
      if (x_last) begin
        line_base   <= line_base + dain_stride;
        rd_req_addr <= line_base + dain_stride;
      end else begin
        rd_req_addr <= line_base + addr_t'(x_cnt) + addr_t'(1);
      end
    end
  end

  // ==============================
  // response capture
  // ==============================
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      rf_wr_en   <= 1'b0;
      rf_wr_last <= 1'b0;
    end else begin
      rf_wr_en   <= rd_rsp_valid;
      rf_wr_last <= rsp_last;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (rd_rsp_valid) begin
      rf_wr_addr <= rf_addr_t'(rsp_cnt);   // k-th response to entry k
      rf_wr_data <= rd_rsp_data;
    end
  end

endmodule

`default_nettype wire

/* design/rbk_rf_core.sv */
/*
 * tile buffer
 * - RF_DEPTH word register array, one write port
 * - registered read port, data one cycle after rf_rd_en
 * - full flag passes the tile from the producer to the consumer
 */
`timescale 1ns/10ps
`default_nettype none

module rbk_rf_core import rbk_pkg::*; (
  input  wire logic     nvdla_core_clk,
  input  wire logic     rst_n,
  input  wire logic     rf_wr_en,
  input  wire rf_addr_t rf_wr_addr,
  input  wire word_t    rf_wr_data,
  input  wire logic     rf_wr_last,
  input  wire logic     rf_rd_en,
  input  wire rf_addr_t rf_rd_addr,
  input  wire logic     rf_rd_last,
  output logic          rf_wr_rdy,
  output logic          tile_ready,
  output word_t         rf_rd_data
);

  word_t mem [RF_DEPTH];
  logic  full;

  // ==============================
  // storage
  // ==============================
  always_ff @(posedge nvdla_core_clk) begin
    if (rf_wr_en) begin
      mem[rf_wr_addr] <= rf_wr_data;
    end
  end

  // holds its value until the next read
  always_ff @(posedge nvdla_core_clk) begin
    if (rf_rd_en) begin
      rf_rd_data <= mem[rf_rd_addr];
    end
  end

  // ==============================
  // tile handoff
  // ==============================
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (rf_wr_en && rf_wr_last) begin
      full <= 1'b1;                       // whole tile landed
    end else if (rf_rd_last) begin
      full <= 1'b0;                       // consumer took the last word
    end
  end

  assign rf_wr_rdy  = ~full;
  assign tile_ready = full;

endmodule

`default_nettype wire

/* design/rbk_wr_req.sv */
/*
 * write requester (consumer)
 * - walks the buffered tile in copy or transpose order
 * - one buffer read per write request, next read only after acceptance
 * - counts write completions and pulses done after the last one
 */
`timescale 1ns/10ps
`default_nettype none

module rbk_wr_req import rbk_pkg::*; (
  input  wire logic        nvdla_core_clk,
  input  wire logic        rst_n,
  input  wire logic        tile_ready,
  input  wire word_t       rf_rd_data,
  input  wire addr_t       daout_addr,
  input  wire addr_t       daout_stride,
  input  wire dim_w_t      tile_w,
  input  wire dim_h_t      tile_h,
  input  wire rubik_mode_t mode,
  input  wire logic        wr_req_ready,
  input  wire logic        wr_rsp_complete,
  output logic             rf_rd_en,
  output rf_addr_t         rf_rd_addr,
  output logic             rf_rd_last,
  output logic             wr_req_valid,
  output addr_t            wr_req_addr,
  output word_t            wr_req_data,
  output logic             done
);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_READ,
    WR_SEND,
    WR_WAIT
  } wr_state_t;

  wr_state_t state;
  dim_w_t    x_cnt;
  dim_h_t    y_cnt;
  addr_t     line_base;   // out base plus outer index times stride
  addr_t     inner_off;
  tile_cnt_t cmp_cnt;
  tile_cnt_t tile_total;
  logic      is_copy;
  logic      x_last;
  logic      y_last;
  logic      inner_last;
  logic      tile_last;
  logic      wr_go;
  logic      cmp_hit;

  assign tile_total = tile_cnt_t'(tile_w) * tile_cnt_t'(tile_h);
  assign is_copy    = (mode == RBK_COPY);
  assign x_last     = (x_cnt == tile_w - dim_w_t'(1));
  assign y_last     = (y_cnt == tile_h - dim_h_t'(1));
  assign inner_last = is_copy ? x_last : y_last;
  assign tile_last  = x_last & y_last;
  assign inner_off  = is_copy ? addr_t'(x_cnt) : addr_t'(y_cnt);
  assign wr_go      = wr_req_valid & wr_req_ready;
  assign cmp_hit    = wr_rsp_complete & (cmp_cnt == tile_total - tile_cnt_t'(1));

  // entry y*W+x, regardless of mode
  assign rf_rd_en     = (state == WR_READ);
  assign rf_rd_addr   = rf_addr_t'(y_cnt) * rf_addr_t'(tile_w) + rf_addr_t'(x_cnt);
  assign rf_rd_last   = rf_rd_en & tile_last;
  assign wr_req_valid = (state == WR_SEND);
  assign wr_req_data  = rf_rd_data;

  // ==============================
  // walk FSM and completions
  // ==============================
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= WR_IDLE;
      x_cnt   <= '0;
      y_cnt   <= '0;
      cmp_cnt <= '0;
      done    <= 1'b0;
    end else begin
      done <= cmp_hit & (state == WR_WAIT);
      if (state == WR_IDLE) cmp_cnt <= '0;
      else if (wr_rsp_complete) cmp_cnt <= cmp_cnt + tile_cnt_t'(1);
      case (state)
        WR_IDLE: begin
          x_cnt <= '0;
          y_cnt <= '0;
          if (tile_ready) state <= WR_READ;
        end
        WR_READ: state <= WR_SEND;
        WR_SEND: begin
          if (wr_go) begin
            if (tile_last) begin
              state <= WR_WAIT;
            end else begin
              state <= WR_READ;
              if (is_copy && x_last) begin
                x_cnt <= '0;
                y_cnt <= y_cnt + dim_h_t'(1);
              end else if (is_copy) begin
                x_cnt <= x_cnt + dim_w_t'(1);
              end else if (y_last) begin
                y_cnt <= '0;
                x_cnt <= x_cnt + dim_w_t'(1);
              end else begin
                y_cnt <= y_cnt + dim_h_t'(1);
              end
            end
          end
        end
        WR_WAIT: if (cmp_hit) state <= WR_IDLE;
        default: state <= WR_IDLE;
      endcase
    end
  end

  // output address for the entry being read
  always_ff @(posedge nvdla_core_clk) begin
    if (state == WR_IDLE) begin
      line_base <= daout_addr;
    end else if (wr_go && inner_last) begin
      line_base <= line_base + daout_stride;   // next output line
    end
    if (state == WR_READ) begin
      wr_req_addr <= line_base + inner_off;
    end
  end

endmodule

`default_nettype wire

/* design/rbk_top.sv */
/*
 * tile rearrangement engine top level
 * - register block, read sequencer, tile buffer, write requester
 */
`timescale 1ns/10ps
`default_nettype none

module rbk_top import rbk_pkg::*; (
  input  wire logic      nvdla_core_clk,
  input  wire logic      rst_n,
  input  wire logic      reg_wr_en,
  input  wire reg_addr_t reg_addr,
  input  wire word_t     reg_wdata,
  output logic           rd_req_valid,
  input  wire logic      rd_req_ready,
  output addr_t          rd_req_addr,
  input  wire logic      rd_rsp_valid,
  input  wire word_t     rd_rsp_data,
  output logic           wr_req_valid,
  input  wire logic      wr_req_ready,
  output addr_t          wr_req_addr,
  output word_t          wr_req_data,
  input  wire logic      wr_rsp_complete,
  output logic           done
);

  logic        op_en;
  addr_t       dain_addr;
  addr_t       dain_stride;
  addr_t       daout_addr;
  addr_t       daout_stride;
  dim_w_t      tile_w;
  dim_h_t      tile_h;
  rubik_mode_t mode;
  logic        rf_wr_en;
  rf_addr_t    rf_wr_addr;
  word_t       rf_wr_data;
  logic        rf_wr_last;
  logic        rf_wr_rdy;
  logic        tile_ready;
  logic        rf_rd_en;
  rf_addr_t    rf_rd_addr;
  logic        rf_rd_last;
  word_t       rf_rd_data;

  rbk_regfile u_regfile (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .reg_wr_en      (reg_wr_en),
    .reg_addr       (reg_addr),
    .reg_wdata      (reg_wdata),
    .done           (done),
    .op_en          (op_en),
    .dain_addr      (dain_addr),
    .dain_stride    (dain_stride),
    .daout_addr     (daout_addr),
    .daout_stride   (daout_stride),
    .tile_w         (tile_w),
    .tile_h         (tile_h),
    .mode           (mode)
  );

  // ==============================
  // datapath
  // ==============================
  rbk_seq_gen u_seq_gen (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .op_en          (op_en),
    .dain_addr      (dain_addr),
    .dain_stride    (dain_stride),
    .tile_w         (tile_w),
    .tile_h         (tile_h),
    .rd_req_ready   (rd_req_ready),
    .rd_rsp_valid   (rd_rsp_valid),
    .rd_rsp_data    (rd_rsp_data),
    .rf_wr_rdy      (rf_wr_rdy),
    .rd_req_valid   (rd_req_valid),
    .rd_req_addr    (rd_req_addr),
    .rf_wr_en       (rf_wr_en),
    .rf_wr_addr     (rf_wr_addr),
    .rf_wr_data     (rf_wr_data),
    .rf_wr_last     (rf_wr_last)
  );

  rbk_rf_core u_rf_core (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .rf_wr_en       (rf_wr_en),
    .rf_wr_addr     (rf_wr_addr),
    .rf_wr_data     (rf_wr_data),
    .rf_wr_last     (rf_wr_last),
    .rf_rd_en       (rf_rd_en),
    .rf_rd_addr     (rf_rd_addr),
    .rf_rd_last     (rf_rd_last),
    .rf_wr_rdy      (rf_wr_rdy),
    .tile_ready     (tile_ready),
    .rf_rd_data     (rf_rd_data)
  );

  rbk_wr_req u_wr_req (
    .nvdla_core_clk  (nvdla_core_clk),
    .rst_n           (rst_n),
    .tile_ready      (tile_ready),
    .rf_rd_data      (rf_rd_data),
    .daout_addr      (daout_addr),
    .daout_stride    (daout_stride),
    .tile_w          (tile_w),
    .tile_h          (tile_h),
    .mode            (mode),
    .wr_req_ready    (wr_req_ready),
    .wr_rsp_complete (wr_rsp_complete),
    .rf_rd_en        (rf_rd_en),
    .rf_rd_addr      (rf_rd_addr),
    .rf_rd_last      (rf_rd_last),
    .wr_req_valid    (wr_req_valid),
    .wr_req_addr     (wr_req_addr),
    .wr_req_data     (wr_req_data),
    .done            (done)          // also clears busy in the regfile
  );

endmodule

`default_nettype wire

/* tests/rbk_mem_model.sv */
/*
 * memory responder for the testbench
 * - random ready stalls on read and write requests
 * - in-order read data after a random latency, address ^ 32'hA5A5_0000
 * - one write completion per accepted write after a random delay
 */
`timescale 1ns/10ps
`default_nettype none

module rbk_mem_model import rbk_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire logic  rd_req_valid,
  input  wire addr_t rd_req_addr,
  output logic       rd_req_ready,
  output logic       rd_rsp_valid,
  output word_t      rd_rsp_data,
  input  wire logic  wr_req_valid,
  output logic       wr_req_ready,
  output logic       wr_rsp_complete
);

  localparam word_t DATA_MASK = 32'hA5A5_0000;

  addr_t rd_addr_q[$];   // accepted reads, in order
  int    rd_due_q[$];    // cycle each read may return
  int    wr_due_q[$];
  int    cyc;

  initial begin
    rd_req_ready    = 1'b0;
    rd_rsp_valid    = 1'b0;
    rd_rsp_data     = '0;
    wr_req_ready    = 1'b0;
    wr_rsp_complete = 1'b0;
    cyc             = 0;
    forever begin
      // ==============================
      // drive on the falling edge
      // ==============================
      @(negedge clk);
      rd_rsp_valid    = 1'b0;
      wr_rsp_complete = 1'b0;
      rd_req_ready    = rst_n && ($urandom % 4 != 0);   // stall one cycle in four
      wr_req_ready    = rst_n && ($urandom % 3 != 0);
      if (rd_due_q.size() != 0 && rd_due_q[0] <= cyc) begin
        rd_rsp_data  = rd_addr_q.pop_front() ^ DATA_MASK;
        rd_rsp_valid = 1'b1;
        void'(rd_due_q.pop_front());
      end
      if (wr_due_q.size() != 0 && wr_due_q[0] <= cyc) begin
        wr_rsp_complete = 1'b1;
        void'(wr_due_q.pop_front());
      end
      // ==============================
      // take requests on the rising edge
      // ==============================
      @(posedge clk);
      cyc = cyc + 1;
      if (rd_req_valid && rd_req_ready) begin
        rd_addr_q.push_back(rd_req_addr);
        rd_due_q.push_back(cyc + int'($urandom % 4));   // head blocks later reads
      end
      if (wr_req_valid && wr_req_ready) begin
        wr_due_q.push_back(cyc + int'($urandom % 5));
      end
    end
  end

endmodule

`default_nettype wire

/* tests/rbk_tb.sv */
/*
 * testbench for the tile rearrangement engine
 * - clock, reset and pattern file loading
 * - register programming and expected read and write streams per operation
 * - read and write monitor with typed compare tasks
 * - watchdog sized from the pattern list
 */
`timescale 1ns/10ps
`default_nettype none

module rbk_tb import rbk_pkg::*; ();

  localparam int    CLK_PERIOD   = 40;
  localparam int    RESET_CYCLES = 16;
  localparam int    SEED         = 32'h32fd;
  localparam        PATTERN_FILE = "tests/rbk_patterns.txt";
  localparam word_t DATA_MASK    = 32'hA5A5_0000;  // memory fill rule

  logic      clk;
  logic      rst_n;
  logic      reg_wr_en;
  reg_addr_t reg_addr;
  word_t     reg_wdata;
  logic      rd_req_valid;
  logic      rd_req_ready;
  addr_t     rd_req_addr;
  logic      rd_rsp_valid;
  word_t     rd_rsp_data;
  logic      wr_req_valid;
  logic      wr_req_ready;
  addr_t     wr_req_addr;
  word_t     wr_req_data;
  logic      wr_rsp_complete;
  logic      done;

  word_t     mode_q[$];         // one entry per operation
  word_t     width_q[$];
  word_t     height_q[$];
  word_t     in_base_q[$];
  word_t     in_stride_q[$];
  word_t     out_base_q[$];
  word_t     out_stride_q[$];
  addr_t     exp_rd_q[$];       // all expected reads of the run
  addr_t     exp_addr_q[$];     // all expected writes of the run
  word_t     exp_data_q[$];
  tile_cnt_t op_total     = '0;
  int        ops_started  = 0;
  int        ops_done     = 0;
  int        rd_ptr       = 0;
  int        wr_ptr       = 0;
  tile_cnt_t wr_seen      = '0;
  tile_cnt_t cmp_seen     = '0;
  int        limit_cycles = 0;

  rbk_top UUT (
    .nvdla_core_clk  (clk),
    .rst_n           (rst_n),
    .reg_wr_en       (reg_wr_en),
    .reg_addr        (reg_addr),
    .reg_wdata       (reg_wdata),
    .rd_req_valid    (rd_req_valid),
    .rd_req_ready    (rd_req_ready),
    .rd_req_addr     (rd_req_addr),
    .rd_rsp_valid    (rd_rsp_valid),
    .rd_rsp_data     (rd_rsp_data),
    .wr_req_valid    (wr_req_valid),
    .wr_req_ready    (wr_req_ready),
    .wr_req_addr     (wr_req_addr),
    .wr_req_data     (wr_req_data),
    .wr_rsp_complete (wr_rsp_complete),
    .done            (done)
  );

  rbk_mem_model u_mem (
    .clk             (clk),
    .rst_n           (rst_n),
    .rd_req_valid    (rd_req_valid),
    .rd_req_addr     (rd_req_addr),
    .rd_req_ready    (rd_req_ready),
    .rd_rsp_valid    (rd_rsp_valid),
    .rd_rsp_data     (rd_rsp_data),
    .wr_req_valid    (wr_req_valid),
    .wr_req_ready    (wr_req_ready),
    .wr_rsp_complete (wr_rsp_complete)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ==============================
  // failure reporting and compares
  // ==============================
  task automatic stop_failed();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic flag_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    stop_failed();
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_data(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_count(input string name, input tile_cnt_t exp, input tile_cnt_t act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
      stop_failed();
    end
  endtask

  // ==============================
  // stimulus
  // ==============================
  task automatic load_patterns();
    int    fd;
    int    n;
    string line;
    word_t fld [7];
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) flag_error("pattern file tests/rbk_patterns.txt could not be opened");
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, "%h %h %h %h %h %h %h",
                  fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6]);
      if (n == 7) begin                        // comment lines give fewer fields
        mode_q.push_back(fld[0]);
        width_q.push_back(fld[1]);
        height_q.push_back(fld[2]);
        in_base_q.push_back(fld[3]);
        in_stride_q.push_back(fld[4]);
        out_base_q.push_back(fld[5]);
        out_stride_q.push_back(fld[6]);
      end
    end
    $fclose(fd);
    if (mode_q.size() == 0) flag_error("pattern file holds no operations");
  endtask

  task automatic write_reg(input reg_addr_t addr, input word_t data);
    @(negedge clk);
    reg_wr_en = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_wr_en = 1'b0;
  endtask

  // entry (x, y) lands at out line `line`, word `off`
  task automatic expect_write(input int idx, input int x, input int y, input int line,
                              input int off);
    exp_addr_q.push_back(out_base_q[idx] + out_stride_q[idx] * addr_t'(line) + addr_t'(off));
    exp_data_q.push_back((in_base_q[idx] + in_stride_q[idx] * addr_t'(y) + addr_t'(x))
                         ^ DATA_MASK);
  endtask

  task automatic run_op(input int idx);
    int w;
    int h;
    w = int'(width_q[idx]);
    h = int'(height_q[idx]);
    write_reg(REG_DAIN_ADDR, in_base_q[idx]);
    write_reg(REG_DAIN_STRIDE, in_stride_q[idx]);
    write_reg(REG_DAOUT_ADDR, out_base_q[idx]);
    write_reg(REG_DAOUT_STRIDE, out_stride_q[idx]);
    write_reg(REG_SIZE, word_t'((h << 4) | w));
    write_reg(REG_MODE, mode_q[idx]);
    for (int y = 0; y < h; y++)
      for (int x = 0; x < w; x++)
        exp_rd_q.push_back(in_base_q[idx] + in_stride_q[idx] * addr_t'(y) + addr_t'(x));
    if (mode_q[idx][0]) begin
      for (int x = 0; x < w; x++)
        for (int y = 0; y < h; y++)
          expect_write(idx, x, y, x, y);       // columns become lines
    end else begin
      for (int y = 0; y < h; y++)
        for (int x = 0; x < w; x++)
          expect_write(idx, x, y, y, x);
    end
    op_total    = tile_cnt_t'(w * h);
    ops_started = ops_started + 1;
    write_reg(REG_OP_EN, 32'd1);
    while (wr_seen != op_total && ops_done != ops_started) @(negedge clk);
    if (ops_done != ops_started)
      write_reg(REG_OP_EN, 32'd1);             // buffer free, still busy
    while (ops_done != ops_started) @(negedge clk);
  endtask

  // ==============================
  // read, write and done monitor
  // ==============================
  always @(posedge clk) begin
    if (rst_n) begin
      if (rd_req_valid && rd_req_ready) begin
        if (rd_ptr >= exp_rd_q.size()) begin
          flag_error("read request issued with no read left in the operation");
        end else begin
          check_addr("rd_req_addr", exp_rd_q[rd_ptr], rd_req_addr);
          rd_ptr = rd_ptr + 1;
        end
      end
      if (wr_rsp_complete) cmp_seen = cmp_seen + tile_cnt_t'(1);
      if (wr_req_valid && wr_req_ready) begin
        if (wr_ptr >= exp_addr_q.size()) begin
          flag_error("write request issued with no write left in the operation");
        end else begin
          check_addr("wr_req_addr", exp_addr_q[wr_ptr], wr_req_addr);
          check_data("wr_req_data", exp_data_q[wr_ptr], wr_req_data);
          wr_ptr  = wr_ptr + 1;
          wr_seen = wr_seen + tile_cnt_t'(1);
        end
      end
      if (done) begin
        if (ops_done == ops_started) begin
          flag_error("done pulse seen with no operation running");
        end else begin
          check_count("writes per operation", op_total, wr_seen);
          check_count("write completions", op_total, cmp_seen);
          wr_seen  = '0;
          cmp_seen = '0;
          ops_done = ops_done + 1;
        end
      end
    end
  end

  initial begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk);
    flag_error($sformatf("watchdog expired after %0d cycles, operations did not finish",
                         limit_cycles));
  end

  initial begin
    int budget;
    void'($urandom(SEED));
    rst_n     = 1'b0;
    reg_wr_en = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    load_patterns();
    budget = RESET_CYCLES + 100;
    foreach (width_q[i]) budget = budget + int'(width_q[i]) * int'(height_q[i]) * 200;
    limit_cycles = budget;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    repeat (4) @(negedge clk);
    for (int i = 0; i < mode_q.size(); i++) run_op(i);
    repeat (40) @(negedge clk);                // quiet tail for late writes or done
    if (ops_done == mode_q.size()) begin
      $display("Testbench passed");
      $finish;
    end else begin
      flag_error($sformatf("only %0d of %0d operations completed", ops_done, mode_q.size()));
    end
  end

endmodule

`default_nettype wire

/* tests/rbk_patterns.txt */
# columns, all hex: mode width height in_base in_stride out_base out_stride
# mode 0 is copy, mode 1 is transpose
0 8 4 00001000 00000010 00008000 00000010
1 8 4 00001000 00000010 00009000 00000004
0 1 1 00002000 00000001 0000a000 00000001
1 1 1 00002004 00000001 0000a100 00000001
0 4 2 00003000 00000040 0000b000 00000020
1 4 2 00003000 00000040 0000b400 00000002
0 3 3 00004010 00000008 0000c000 00000100
1 3 3 00004010 00000008 0000c800 00000003
0 8 1 00005000 00000000 0000d000 00000000
1 8 1 00005000 00000000 0000d100 00000001
0 1 4 00006000 00000020 0000e000 00000010
1 1 4 00006000 00000020 0000e200 00000004
0 5 3 0000f000 00000100 00010000 00000080
1 7 4 00011000 00000009 00012000 00000010
0 2 4 fffffff0 00000004 00013000 00000002
1 6 2 00014000 00000006 00015000 00000002
1 8 4 00016000 00000008 00017000 00000004
0 8 4 00018000 00000008 00019000 00000008

/* vlog.f */
design/rbk_pkg.sv
design/rbk_regfile.sv
design/rbk_seq_gen.sv
design/rbk_rf_core.sv
design/rbk_wr_req.sv
design/rbk_top.sv
tests/rbk_mem_model.sv
tests/rbk_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the tile engine testbench with Verilator
set -e

cd "$(dirname "$0")"
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -j 0 -f vlog.f --top-module rbk_tb

# the simulator exits non-zero on failure, the log decides the result
./obj_dir/Vrbk_tb | tee "$LOG"

if grep -q "Testbench failed" "$LOG"; then
  echo "simulation FAILED, see $LOG"
  exit 1
fi
if ! grep -q "Testbench passed" "$LOG"; then
  echo "simulation ended without a result, see $LOG"
  exit 1
fi
echo "simulation PASSED"
